//--- build.f
design/rs_pkg.sv
design/rs_entry.sv
design/rs_issue_select.sv
design/rs_station.sv
design/rs_top.sv
bench/rs_tb.sv

//--- Makefile
TOP := rs_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o $(TOP)

# The run passes only if the testbench printed its pass line
run: build
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

//--- bench/rs_tb.sv
`timescale 1ns/1ps

module rs_tb;

    import rs_pkg::*;

    // Longest wait in cycles for any handshake
    localparam int TIMEOUT = 50;

    logic         clk;
    logic         i_rst_n;
    logic         i_flush;
    logic         i_dispatch_valid;
    rs_dispatch_t i_dispatch;
    logic         o_dispatch_ready;
    cdb_bus_t     i_cdb;
    logic         o_issue_valid;
    rs_issue_t    o_issue;
    logic         i_issue_ready;

    int errors;
    int checks;
    int tests;
    int test_start;

    rs_top DUT (.*);

    always #5 clk = ~clk;

    task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                               input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    // Random instruction with both sources ready
    // Tests clear the ready bits they need
    function automatic rs_dispatch_t random_instr();
        rs_dispatch_t d;
        d.op       = op_t'($urandom);
        d.op_is    = op_is_t'($urandom);
        d.imm      = $urandom;
        d.dst_tag  = tag_t'($urandom);
        d.src_rdy  = 2'b11;
        d.src_data = {$urandom, $urandom};
        d.src_tag  = {tag_t'($urandom), tag_t'($urandom)};
        return d;
    endfunction

    // A functional unit sees the fields of the dispatch plus the final operands
    function automatic rs_issue_t expected_issue(input rs_dispatch_t d, input data_t s0,
                                                 input data_t s1);
        return '{op: d.op, op_is: d.op_is, imm: d.imm, src_data: {s1, s0}, dst_tag: d.dst_tag};
    endfunction

    function automatic cdb_bus_t one_bus(input int bus, input tag_t tag, input data_t data);
        cdb_bus_t c;
        c = '0;
        c[bus] = '{en: 1'b1, tag: tag, data: data};
        return c;
    endfunction

    // Drives the result buses for exactly one edge
    task automatic broadcast(input cdb_bus_t c);
        @(posedge clk);
        i_cdb <= c;
        @(posedge clk);
        i_cdb <= '0;
    endtask

    // Returns right after the edge that accepted the instruction
    task automatic dispatch_instr(input rs_dispatch_t d);
        int waited;
        waited = 0;
        @(posedge clk);
        i_dispatch_valid <= 1'b1;
        i_dispatch       <= d;
        @(negedge clk);
        while (!o_dispatch_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_dispatch_ready) begin
            errors++;
            $display("dispatch was not accepted within %0d cycles", TIMEOUT);
        end
        @(posedge clk);
        i_dispatch_valid <= 1'b0;
    endtask

    // Waits for an offer, checks it, then accepts it with a one-cycle ready pulse
    task automatic pop_issue(input rs_issue_t exp, input string msg);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!o_issue_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_issue_valid) begin
            errors++;
            $display("no instruction was offered within %0d cycles", TIMEOUT);
        end
        check_equal(o_issue, exp, msg);
        @(posedge clk);
        i_issue_ready <= 1'b1;
        @(posedge clk);
        i_issue_ready <= 1'b0;
    endtask

    task automatic expect_no_issue(input int cycles, input string msg);
        repeat (cycles) begin
            @(negedge clk);
            check_equal(o_issue_valid, 1'b0, msg);
        end
    endtask

    task automatic flush_pulse();
        @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_equal(o_issue_valid, 1'b0, "issue valid after reset");
        check_equal(o_dispatch_ready, 1'b1, "dispatch ready after reset");
        report_test("reset state");
    endtask

    task automatic test_ready_dispatch();
        rs_dispatch_t d;
        d = random_instr();
        @(posedge clk);
        i_issue_ready <= 1'b1;
        dispatch_instr(d);
        // Both operands present, so the offer comes in the very next cycle
        @(negedge clk);
        check_equal(o_issue_valid, 1'b1, "issue valid one cycle after dispatch");
        check_equal(o_issue, expected_issue(d, d.src_data[0], d.src_data[1]), "issued payload");
        @(posedge clk);
        i_issue_ready <= 1'b0;
        @(negedge clk);
        check_equal(o_issue_valid, 1'b0, "issue valid after the issue");
        report_test("ready at dispatch");
    endtask

    task automatic test_wakeup();
        rs_dispatch_t d;
        data_t v0;
        data_t v1;
        v0 = $urandom;
        v1 = $urandom;
        d = random_instr();
        d.src_rdy    = 2'b00;
        d.src_tag[1] = d.src_tag[0] + tag_t'(1);
        dispatch_instr(d);
        expect_no_issue(3, "issue while both sources wait");
        broadcast(one_bus(1, d.src_tag[0], v0));
        expect_no_issue(3, "issue while source 1 waits");
        broadcast(one_bus(0, d.src_tag[1], v1));
        pop_issue(expected_issue(d, v0, v1), "payload after wakeup");
        // Source 0 is ready, so a broadcast of its tag must not replace its data
        d = random_instr();
        d.src_rdy    = 2'b01;
        d.src_tag[1] = d.src_tag[0] + tag_t'(1);
        dispatch_instr(d);
        broadcast(one_bus(0, d.src_tag[0], ~d.src_data[0]) | one_bus(1, d.src_tag[1], v1));
        pop_issue(expected_issue(d, d.src_data[0], v1), "ready source kept its data");
        report_test("operand wakeup");
    endtask

    task automatic test_oldest();
        rs_dispatch_t p;
        rs_dispatch_t a;
        rs_dispatch_t b;
        rs_dispatch_t c;
        tag_t         base;
        data_t        z;
        base = tag_t'($urandom);
        z    = $urandom;
        p = random_instr();
        p.src_rdy    = 2'b10;
        p.src_tag[0] = base;
        a = random_instr();
        a.src_rdy = 2'b00;
        a.src_tag = {base + tag_t'(4), base + tag_t'(1)};
        b = random_instr();
        b.src_rdy = 2'b00;
        b.src_tag = {base + tag_t'(4), base + tag_t'(2)};
        c = random_instr();
        c.src_rdy = 2'b00;
        c.src_tag = {base + tag_t'(4), base + tag_t'(3)};
        dispatch_instr(p);
        dispatch_instr(a);
        dispatch_instr(b);
        // Broadcast operands differ from the data sent with the dispatch
        broadcast(one_bus(0, base, ~p.src_data[0]));
        pop_issue(expected_issue(p, ~p.src_data[0], p.src_data[1]), "first filler out");
        // C lands in the freed lowest slot but is still the youngest
        dispatch_instr(c);
        broadcast(one_bus(0, c.src_tag[0], ~c.src_data[0])
                  | one_bus(1, b.src_tag[0], ~b.src_data[0]));
        broadcast(one_bus(1, a.src_tag[0], ~a.src_data[0]));
        expect_no_issue(2, "issue before the shared tag");
        broadcast(one_bus(0, base + tag_t'(4), z));
        pop_issue(expected_issue(a, ~a.src_data[0], z), "oldest issues first");
        pop_issue(expected_issue(b, ~b.src_data[0], z), "middle issues second");
        pop_issue(expected_issue(c, ~c.src_data[0], z), "youngest issues last");
        report_test("oldest first");
    endtask

    task automatic test_backpressure();
        rs_dispatch_t x;
        rs_issue_t    held;
        x    = random_instr();
        held = expected_issue(x, x.src_data[0], x.src_data[1]);
        dispatch_instr(x);
        for (int i = 1; i < RS_DEPTH; i++) begin
            dispatch_instr(random_instr());
            @(negedge clk);
            check_equal(o_issue, held, "payload held under back-pressure");
        end
        check_equal(o_dispatch_ready, 1'b0, "dispatch ready with every entry full");
        pop_issue(held, "held payload taken");
        @(negedge clk);
        check_equal(o_dispatch_ready, 1'b1, "dispatch ready after one issue");
        flush_pulse();
        report_test("back-pressure and full");
    endtask

    task automatic test_flush();
        rs_dispatch_t d;
        tag_t         base;
        base = tag_t'($urandom);
        for (int i = 0; i < 3; i++) begin
            d = random_instr();
            // The first one is ready at once so the flush has an offer to cancel
            d.src_rdy    = (i == 0) ? 2'b11 : 2'b10;
            d.src_tag[0] = base + tag_t'(i);
            dispatch_instr(d);
        end
        @(negedge clk);
        check_equal(o_issue_valid, 1'b1, "issue valid before flush");
        flush_pulse();
        broadcast(one_bus(0, base + tag_t'(1), $urandom) | one_bus(1, base + tag_t'(2), $urandom));
        expect_no_issue(3, "issue valid after flush");
        check_equal(o_dispatch_ready, 1'b1, "dispatch ready after flush");
        report_test("flush");
    endtask

    initial begin
        clk              = 1'b0;
        i_rst_n          = 1'b0;
        i_flush          = 1'b0;
        i_dispatch_valid = 1'b0;
        i_dispatch       = '0;
        i_cdb            = '0;
        i_issue_ready    = 1'b0;
        errors           = 0;
        checks           = 0;
        tests            = 0;
        test_start       = 0;
        void'($urandom(94));
        repeat (3) @(posedge clk);
        i_rst_n <= 1'b1;
        test_reset();
        test_ready_dispatch();
        test_wakeup();
        test_oldest();
        test_backpressure();
        test_flush();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- design/rs_top.sv
`timescale 1ns/1ps

module rs_top (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  logic                 i_dispatch_valid,
    input  rs_pkg::rs_dispatch_t i_dispatch,
    output logic                 o_dispatch_ready,
    input  rs_pkg::cdb_bus_t     i_cdb,
    output logic                 o_issue_valid,
    output rs_pkg::rs_issue_t    o_issue,
    input  logic                 i_issue_ready
);

    // Single station between the dispatcher and one functional unit
    rs_station u_station (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_flush          (i_flush),
        .i_dispatch_valid (i_dispatch_valid),
        .i_dispatch       (i_dispatch),
        .i_cdb            (i_cdb),
        .i_issue_ready    (i_issue_ready),
        .o_dispatch_ready (o_dispatch_ready),
        .o_issue_valid    (o_issue_valid),
        .o_issue          (o_issue)
    );

endmodule

//--- design/rs_station.sv
`timescale 1ns/1ps

module rs_station (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  logic                 i_dispatch_valid,
    input  rs_pkg::rs_dispatch_t i_dispatch,
    input  rs_pkg::cdb_bus_t     i_cdb,
    input  logic                 i_issue_ready,
    output logic                 o_dispatch_ready,
    output logic                 o_issue_valid,
    output rs_pkg::rs_issue_t    o_issue
);

    import rs_pkg::*;

    // What every entry shows the station
    rs_entry_t [RS_DEPTH-1:0] entries;
    rs_mask_t                 ready_mask;
    rs_mask_t                 empty_mask;
    age_t [RS_DEPTH-1:0]      ages;

    // Per-entry steering of dispatch and issue
    rs_mask_t                 dispatch_en;
    rs_mask_t                 issue_en;

    logic                     issue_found;
    age_t                     issue_idx;
    logic                     free_found;
    age_t                     free_idx;

    // Broadcast to all entries for the age update
    logic                     dispatching;
    logic                     issuing;
    age_t                     issue_age;

    // Room exists whenever an entry is empty
    assign o_dispatch_ready = free_found;
    assign o_issue_valid    = issue_found;

    // Flush overrides a dispatch in the same cycle
    assign dispatching = i_dispatch_valid && o_dispatch_ready && !i_flush;
    assign issuing     = o_issue_valid && i_issue_ready;

    // The selected entry's payload and age go out directly
    assign o_issue   = entries[issue_idx].issue;
    assign issue_age = entries[issue_idx].age;

    for (genvar g = 0; g < RS_DEPTH; g++) begin : g_entry
        assign empty_mask[g]  = entries[g].empty;
        assign ages[g]        = entries[g].age;
        assign dispatch_en[g] = dispatching && (free_idx == age_t'(g));
        assign issue_en[g]    = issuing && (issue_idx == age_t'(g));

        rs_entry u_entry (
            .clk           (clk),
            .i_rst_n       (i_rst_n),
            .i_flush       (i_flush),
            .i_dispatch_en (dispatch_en[g]),
            .i_dispatch    (i_dispatch),
            .i_cdb         (i_cdb),
            .i_issue_en    (issue_en[g]),
            .i_dispatching (dispatching),
            .i_issuing     (issuing),
            .i_issue_age   (issue_age),
            .o_ready       (ready_mask[g]),
            .o_entry       (entries[g])
        );
    end

    // Picks the oldest ready entry and the next free slot
    rs_issue_select u_select (
        .i_ready_mask  (ready_mask),
        .i_empty_mask  (empty_mask),
        .i_ages        (ages),
        .o_issue_found (issue_found),
        .o_issue_idx   (issue_idx),
        .o_free_found  (free_found),
        .o_free_idx    (free_idx)
    );

    // A stalled offer holds until taken.
    // New dispatches arrive younger and the selected entry's operands are
    // already complete, so only a flush may withdraw it
    a_issue_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_issue_valid && !i_issue_ready && !i_flush)
        |=> (o_issue_valid && $stable(o_issue)));

endmodule

//--- design/rs_issue_select.sv
`timescale 1ns/1ps

module rs_issue_select (
    input  rs_pkg::rs_mask_t                    i_ready_mask,
    input  rs_pkg::rs_mask_t                    i_empty_mask,
    input  rs_pkg::age_t [rs_pkg::RS_DEPTH-1:0] i_ages,
    output logic                                o_issue_found,
    output rs_pkg::age_t                        o_issue_idx,
    output logic                                o_free_found,
    output rs_pkg::age_t                        o_free_idx
);

    import rs_pkg::*;

    // Oldest ready entry wins.
    // Ready entries never share an age, so the first one found with the
    // largest age is the only candidate
    always_comb begin
        age_t best_age;
        o_issue_found = 1'b0;
        o_issue_idx   = '0;
        best_age      = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (i_ready_mask[i] && (!o_issue_found || (i_ages[i] > best_age))) begin
                o_issue_found = 1'b1;
                o_issue_idx   = age_t'(i);
                best_age      = i_ages[i];
            end
        end
    end

    // Lowest-index empty entry takes the next dispatch.
    // Scanning downward lets the lowest match overwrite the rest
    always_comb begin
        o_free_found = 1'b0;
        o_free_idx   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (i_empty_mask[i]) begin
                o_free_found = 1'b1;
                o_free_idx   = age_t'(i);
            end
        end
    end

endmodule

//--- design/rs_entry.sv
`timescale 1ns/1ps

module rs_entry (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  logic                 i_dispatch_en,
    input  rs_pkg::rs_dispatch_t i_dispatch,
    input  rs_pkg::cdb_bus_t     i_cdb,
    input  logic                 i_issue_en,
    input  logic                 i_dispatching,
    input  logic                 i_issuing,
    input  rs_pkg::age_t         i_issue_age,
    output logic                 o_ready,
    output rs_pkg::rs_entry_t    o_entry
);

    import rs_pkg::*;

    // Control state of the entry
    logic        empty_r;
    age_t        age_r;
    age_t        age_nxt;
    logic [1:0]  src_rdy_r;
    logic [1:0]  src_rdy_nxt;

    // Payload of the waiting instruction and the tags its sources wait on
    rs_issue_t   issue_r;
    tag_t [1:0]  src_tag_r;
    data_t [1:0] src_data_nxt;

    // Issue or flush frees the entry, dispatch claims it
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            empty_r <= 1'b1;
        end else if (i_flush || i_issue_en) begin
            empty_r <= 1'b1;
        end else if (i_dispatch_en) begin
            empty_r <= 1'b0;
        end
    end

    // A source still waiting compares its tag against every enabled bus.
    // Later buses override earlier ones, so the highest-numbered bus wins
    // if the outside ever breaks the one-tag-per-cycle rule.
    // A source that is already ready keeps its data whatever is broadcast,
    // which matters for tag 0 standing in for the zero register
    always_comb begin
        src_rdy_nxt  = src_rdy_r;
        src_data_nxt = issue_r.src_data;
        for (int s = 0; s < 2; s++) begin
            for (int c = 0; c < CDB_DEPTH; c++) begin
                if (!src_rdy_r[s] && i_cdb[c].en && (i_cdb[c].tag == src_tag_r[s])) begin
                    src_rdy_nxt[s]  = 1'b1;
                    src_data_nxt[s] = i_cdb[c].data;
                end
            end
        end
        // A new instruction replaces whatever was snooped
        if (i_dispatch_en) begin
            src_rdy_nxt  = i_dispatch.src_rdy;
            src_data_nxt = i_dispatch.src_data;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            src_rdy_r <= '0;
        end else begin
            src_rdy_r <= src_rdy_nxt;
        end
    end

    // Operation fields only load on dispatch, source data follows the snoop
    always_ff @(posedge clk) begin
        if (i_dispatch_en) begin
            issue_r.op      <= i_dispatch.op;
            issue_r.op_is   <= i_dispatch.op_is;
            issue_r.imm     <= i_dispatch.imm;
            issue_r.dst_tag <= i_dispatch.dst_tag;
            src_tag_r       <= i_dispatch.src_tag;
        end
        issue_r.src_data <= src_data_nxt;
    end

    // Ages keep the non-empty entries ordered, highest is oldest.
    // Dispatch alone pushes everyone back by one and the new entry starts at 0.
    // Issue alone closes the gap above the leaving entry.
    // With both, only entries younger than the leaving one move up
    always_comb begin
        unique case ({i_dispatching, i_issuing})
            2'b00: age_nxt = age_r;
            2'b01: age_nxt = (age_r > i_issue_age) ? age_r - age_t'(1) : age_r;
            2'b10: age_nxt = i_dispatch_en ? '0 : age_r + age_t'(1);
            2'b11: age_nxt = i_dispatch_en ? '0
                           : ((age_r < i_issue_age) ? age_r + age_t'(1) : age_r);
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            age_r <= '0;
        end else if (i_flush) begin
            age_r <= '0;
        end else begin
            age_r <= age_nxt;
        end
    end

    // Ready to go once occupied and holding both operands
    assign o_ready = !empty_r && (&src_rdy_r);
    assign o_entry = '{empty: empty_r, age: age_r, issue: issue_r};

    // The station must never aim dispatch and issue at the same entry
    a_no_dispatch_and_issue: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_dispatch_en && i_issue_en));

    // Issue select may only pick an entry that holds both operands
    a_issue_only_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_issue_en |-> o_ready);

    // Allocation must pick a free entry
    a_dispatch_into_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_dispatch_en |-> empty_r);

endmodule

//--- design/rs_pkg.sv
package rs_pkg;

    // Operand and immediate width
    localparam int DATA_W    = 32;
    // Reorder buffer tag width
    localparam int TAG_W     = 5;
    localparam int RS_DEPTH  = 8;
    // Wide enough to hold both an entry index and an age
    localparam int AGE_W     = 3;
    // Number of result buses snooped by every entry
    localparam int CDB_DEPTH = 2;
    localparam int OP_W      = 6;
    localparam int OP_IS_W   = 3;

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [AGE_W-1:0]    age_t;
    typedef logic [OP_W-1:0]     op_t;
    typedef logic [OP_IS_W-1:0]  op_is_t;
    typedef logic [RS_DEPTH-1:0] rs_mask_t;

    // One dispatched instruction, index 0 and 1 select the source operand
    typedef struct packed {
        op_t              op;
        op_is_t           op_is;
        data_t            imm;
        tag_t             dst_tag;
        logic [1:0]       src_rdy;
        data_t [1:0]      src_data;
        tag_t [1:0]       src_tag;
    } rs_dispatch_t;

    // One result bus
    typedef struct packed {
        logic  en;
        tag_t  tag;
        data_t data;
    } cdb_t;

    typedef cdb_t [CDB_DEPTH-1:0] cdb_bus_t;

    // What a functional unit receives on issue
    typedef struct packed {
        op_t         op;
        op_is_t      op_is;
        data_t       imm;
        data_t [1:0] src_data;
        tag_t        dst_tag;
    } rs_issue_t;

    // What one entry shows the station
    typedef struct packed {
        logic      empty;
        age_t      age;
        rs_issue_t issue;
    } rs_entry_t;

endpackage
